//--- include/decode_settings.svh
// widths and depths of the decode-to-uop-queue path for the package and RTL to include
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// decoded units and slots per unit / per push row
`define NUM_DE_INST 2
`define NUM_DE_UOP 4

// uop fields
`define UOP_INDEX_WIDTH 3
`define UOP_PAYLOAD_WIDTH 16

// uop queue depth as a power of two with its pointer width
`define UQ_DEPTH 16
`define UQ_PTR_WIDTH 4

`endif

//--- hw/decode_pkg.sv
// shared typedefs and structs for the decode controller and the uop queue
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

  // position of a uop within its instruction
  typedef logic [`UOP_INDEX_WIDTH-1:0] uop_index_t;

  // opaque uop body
  typedef logic [`UOP_PAYLOAD_WIDTH-1:0] uop_payload_t;

  // one valid bit per slot
  typedef logic [`NUM_DE_UOP-1:0] uop_mask_t;

  // 0 to NUM_DE_UOP valid uops
  typedef logic [$clog2(`NUM_DE_UOP+1)-1:0] uop_count_t;

  // queue occupancy from 0 to UQ_DEPTH
  typedef logic [`UQ_PTR_WIDTH:0] uq_count_t;

  typedef struct packed {
    uop_index_t   uop_index;
    logic         last_uop_valid;
    uop_payload_t payload;
  } uop_t;

  typedef uop_t [`NUM_DE_UOP-1:0] uop_row_t;

  // one decoded instruction package as offered to the controller
  typedef struct packed {
    logic      pkg_valid;
    uop_mask_t mask;
    uop_row_t  uops;
  } de_unit_t;

endpackage

`default_nettype wire

//--- hw/uop_merge.sv
// packs the uops of two decoded units into one push row and finds their last uops
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module uop_merge (
  input  decode_pkg::de_unit_t   unit0,
  input  decode_pkg::de_unit_t   unit1,
  output decode_pkg::uop_count_t q,
  output decode_pkg::uop_mask_t  row_valid,
  output decode_pkg::uop_row_t   row_data,
  output logic                   last0,
  output logic                   last1
);

  decode_pkg::uop_row_t unit1_shift;

  // unit 0 mask is a thermometer code, so a popcount gives its length
  always_comb begin
    q = '0;
    for (int i = 0; i < `NUM_DE_UOP; i++) begin
      q = q + decode_pkg::uop_count_t'(unit0.mask[i]);
    end
  end

  // unit 1 moved up behind unit 0
  assign unit1_shift = unit1.uops << (q * $bits(decode_pkg::uop_t));

  // slots below q belong to unit 0, the rest to shifted unit 1
  assign row_valid = unit0.mask | decode_pkg::uop_mask_t'(unit1.mask << q);

  always_comb begin
    for (int j = 0; j < `NUM_DE_UOP; j++) begin
      if (unit0.mask[j]) begin
        row_data[j] = unit0.uops[j];
      end else begin
        row_data[j] = unit1_shift[j];
      end
    end
  end

  // a short unit 0 row always holds its last uop
  always_comb begin
    case (q)
      decode_pkg::uop_count_t'(0): begin
        last0 = 1'b0;
      end
      decode_pkg::uop_count_t'(`NUM_DE_UOP): begin
        last0 = unit0.uops[`NUM_DE_UOP-1].last_uop_valid;
      end
      default: begin
        last0 = 1'b1;
      end
    endcase
  end

  // unit 1 only gets the slots left free by unit 0
  always_comb begin
    last1 = 1'b0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (k + int'(q) < `NUM_DE_UOP) begin
        last1 = last1 | unit1.uops[k].last_uop_valid;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/decode_ctrl.sv
// producer side that gates the packed row into the uop queue and pops the command queue
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module decode_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  decode_pkg::de_unit_t      unit0,
  input  decode_pkg::de_unit_t      unit1,
  input  logic                      uq_ready,
  output logic [`NUM_DE_INST-1:0]   pop,
  output decode_pkg::uop_mask_t     push,
  output decode_pkg::uop_row_t      push_data,
  output decode_pkg::uop_index_t    uop_index_remain
);

  decode_pkg::uop_count_t q;
  decode_pkg::uop_mask_t  row_valid;
  logic                   last0;
  logic                   last1;
  logic                   mask0_zero;
  logic                   mask1_zero;
  logic                   idx_clear;
  logic                   idx_en0;
  logic                   idx_en1;
  decode_pkg::uop_index_t idx_unit1;

  uop_merge u_merge (
    .unit0     (unit0),
    .unit1     (unit1),
    .q         (q),
    .row_valid (row_valid),
    .row_data  (push_data),
    .last0     (last0),
    .last1     (last1)
  );

  assign mask0_zero = (unit0.mask == '0);
  assign mask1_zero = (unit1.mask == '0);

  // the queue takes a whole row only with NUM_DE_UOP free entries
  assign push = row_valid & {`NUM_DE_UOP{uq_ready}};

  // empty-mask units pop even under back-pressure
  assign pop[0] = unit0.pkg_valid & ((last0 & uq_ready) | mask0_zero);
  assign pop[1] = pop[0] & unit1.pkg_valid & ((last1 & uq_ready) | mask1_zero);

  // resume index control
  assign idx_clear = (pop[0] & ~unit1.pkg_valid) | pop[1];
  assign idx_en0   = unit0.pkg_valid & ~mask0_zero & ~last0 & uq_ready;
  assign idx_en1   = unit1.pkg_valid & ~mask1_zero & ~last1 & uq_ready & pop[0];

  // index after the last unit 1 uop that made it into the row
  always_comb begin
    idx_unit1 = '0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (k + int'(q) == `NUM_DE_UOP - 1) begin
        idx_unit1 = unit1.uops[k].uop_index + 1'b1;
      end
    end
  end

  // en0 needs unit 0 unpopped so it never meets en1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uop_index_remain <= '0;
    end else if (idx_clear) begin
      uop_index_remain <= '0;
    end else if (idx_en0) begin
      uop_index_remain <= unit0.uops[`NUM_DE_UOP-1].uop_index + 1'b1;
    end else if (idx_en1) begin
      uop_index_remain <= idx_unit1;
    end
  end

endmodule

`default_nettype wire

//--- hw/uop_queue.sv
// uop FIFO taking up to NUM_DE_UOP writes per cycle and giving one read per cycle
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module uop_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  decode_pkg::uop_mask_t push,
  input  decode_pkg::uop_row_t  push_data,
  input  logic                  rd_pop,
  output logic                  uq_ready,
  output logic                  uq_valid,
  output decode_pkg::uop_t      uq_data
);

  decode_pkg::uop_t         mem [`UQ_DEPTH];
  logic [`UQ_PTR_WIDTH-1:0] wr_ptr;
  logic [`UQ_PTR_WIDTH-1:0] rd_ptr;
  decode_pkg::uq_count_t    count;
  logic [`UQ_PTR_WIDTH-1:0] push_cnt;
  logic [`UQ_PTR_WIDTH-1:0] slot_pos [`NUM_DE_UOP];
  logic                     rd_en;

  // each pushed slot lands right after the previous pushed one
  always_comb begin
    push_cnt = '0;
    for (int j = 0; j < `NUM_DE_UOP; j++) begin
      slot_pos[j] = wr_ptr + push_cnt;
      push_cnt    = push_cnt + {{(`UQ_PTR_WIDTH-1){1'b0}}, push[j]};
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < `NUM_DE_UOP; j++) begin
      if (push[j]) begin
        mem[slot_pos[j]] <= push_data[j];
      end
    end
  end

  // reads from an empty queue are dropped
  assign rd_en = rd_pop & uq_valid;

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + push_cnt;
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {1'b0, push_cnt} - {{`UQ_PTR_WIDTH{1'b0}}, rd_en};
    end
  end

  assign uq_valid = (count != '0);

  // room for a full row
  assign uq_ready = (count <= decode_pkg::uq_count_t'(`UQ_DEPTH - `NUM_DE_UOP));

  assign uq_data = mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/decode_uop_top.sv
// top level joining the decode controller to the uop queue
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module decode_uop_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  decode_pkg::de_unit_t    de_unit0,
  input  decode_pkg::de_unit_t    de_unit1,
  input  logic                    uq_pop,
  output logic [`NUM_DE_INST-1:0] pop,
  output decode_pkg::uop_index_t  uop_index_remain,
  output logic                    uq_valid,
  output decode_pkg::uop_t        uq_data
);

  logic                  uq_ready;
  decode_pkg::uop_mask_t push;
  decode_pkg::uop_row_t  push_data;

  decode_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .unit0            (de_unit0),
    .unit1            (de_unit1),
    .uq_ready         (uq_ready),
    .pop              (pop),
    .push             (push),
    .push_data        (push_data),
    .uop_index_remain (uop_index_remain)
  );

  // reader side is a bare pop strobe
  uop_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .rd_pop    (uq_pop),
    .uq_ready  (uq_ready),
    .uq_valid  (uq_valid),
    .uq_data   (uq_data)
  );

endmodule

`default_nettype wire

//--- tb/tb_decode_uop_top.sv
// testbench for decode_uop_top playing both decoders and the queue reader
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module tb_decode_uop_top;

  typedef struct packed {
    logic [`NUM_DE_INST-1:0] pop;
    decode_pkg::uop_index_t  next_index;
    decode_pkg::uop_mask_t   push;
    decode_pkg::uop_row_t    row;
  } ref_result_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  decode_pkg::de_unit_t    de_unit0;
  decode_pkg::de_unit_t    de_unit1;
  logic                    uq_pop;
  logic [`NUM_DE_INST-1:0] pop;
  decode_pkg::uop_index_t  uop_index_remain;
  logic                    uq_valid;
  decode_pkg::uop_t        uq_data;

  decode_pkg::uop_t        exp_q[$];
  decode_pkg::uop_index_t  exp_index;
  ref_result_t             chk_res;
  int                      cmd_len[64];
  int                      pops_seen;
  int                      errors;
  bit                      aborted;
  string                   cur_test;

  decode_uop_top u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .de_unit0         (de_unit0),
    .de_unit1         (de_unit1),
    .uq_pop           (uq_pop),
    .pop              (pop),
    .uop_index_remain (uop_index_remain),
    .uq_valid         (uq_valid),
    .uq_data          (uq_data)
  );

  always #4 clk = ~clk;

  // one instruction of len uops offered from uop index start
  function automatic decode_pkg::de_unit_t make_unit(input bit valid, input int id,
                                                     input int len, input int start);
    decode_pkg::de_unit_t u;
    int idx;
    u = '0;
    u.pkg_valid = valid;
    for (int s = 0; s < `NUM_DE_UOP; s++) begin
      idx = start + s;
      if (valid && idx < len) begin
        u.mask[s] = 1'b1;
        u.uops[s].uop_index = decode_pkg::uop_index_t'(idx);
        u.uops[s].last_uop_valid = (idx == len - 1);
        u.uops[s].payload = {id[12:0], idx[2:0]};
      end
    end
    return u;
  endfunction

  function automatic ref_result_t ref_model(input decode_pkg::de_unit_t u0,
                                            input decode_pkg::de_unit_t u1,
                                            input int occ, input decode_pkg::uop_index_t idx);
    ref_result_t r;
    int q;
    logic ready, last0, last1, slot_ok, zero0, zero1, clear, en0, en1;
    r = '0;
    q = 0;
    last1 = 1'b0;
    ready = (occ <= `UQ_DEPTH - `NUM_DE_UOP);
    for (int j = 0; j < `NUM_DE_UOP; j++) begin
      q += int'(u0.mask[j]);
    end
    for (int j = 0; j < `NUM_DE_UOP; j++) begin
      slot_ok = (j < q) ? u0.mask[j] : u1.mask[j-q];
      r.row[j] = (j < q) ? u0.uops[j] : u1.uops[j-q];
      r.push[j] = slot_ok & ready;
    end
    last0 = (q == 0) ? 1'b0 : (q == `NUM_DE_UOP) ? u0.uops[`NUM_DE_UOP-1].last_uop_valid : 1'b1;
    for (int j = 0; j < `NUM_DE_UOP - q; j++) begin
      last1 |= u1.uops[j].last_uop_valid;
    end
    zero0 = (u0.mask == '0);
    zero1 = (u1.mask == '0);
    r.pop[0] = u0.pkg_valid & ((last0 & ready) | zero0);
    r.pop[1] = r.pop[0] & u1.pkg_valid & ((last1 & ready) | zero1);
    clear = (r.pop[0] & ~u1.pkg_valid) | r.pop[1];
    en0 = u0.pkg_valid & ~zero0 & ~last0 & ready;
    en1 = u1.pkg_valid & ~zero1 & ~last1 & ready & r.pop[0];
    r.next_index = idx;
    if (clear) begin
      r.next_index = '0;
    end else if (en0) begin
      r.next_index = u0.uops[`NUM_DE_UOP-1].uop_index + 3'd1;
    end else if (en1) begin
      // no unit 1 uop fits when unit 0 fills the row
      r.next_index = (q < `NUM_DE_UOP) ? u1.uops[`NUM_DE_UOP-1-q].uop_index + 3'd1 : '0;
    end
    return r;
  endfunction

  task automatic check_pop(input string name, input logic [`NUM_DE_INST-1:0] exp,
                           input logic [`NUM_DE_INST-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Error %s pop: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_index(input string name, input decode_pkg::uop_index_t exp,
                             input decode_pkg::uop_index_t act);
    if (act !== exp) begin
      errors++;
      $display("Error %s uop_index_remain: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_uop(input string name, input decode_pkg::uop_t exp,
                           input decode_pkg::uop_t act);
    if (act !== exp) begin
      errors++;
      $display("Error %s uq_data: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Error %s uq_valid: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("timeout in %s: %s", cur_test, what);
  endtask

  // scoreboard sampling inputs that are stable since the last falling edge
  always @(posedge clk) begin
    if (rst_n) begin
      chk_res = ref_model(de_unit0, de_unit1, exp_q.size(), exp_index);
      check_pop(cur_test, chk_res.pop, pop);
      check_index(cur_test, exp_index, uop_index_remain);
      check_valid(cur_test, exp_q.size() != 0, uq_valid);
      if (exp_q.size() != 0) begin
        check_uop(cur_test, exp_q[0], uq_data);
        if (uq_pop) begin
          void'(exp_q.pop_front());
        end
      end
      for (int j = 0; j < `NUM_DE_UOP; j++) begin
        if (chk_res.push[j]) begin
          exp_q.push_back(chk_res.row[j]);
        end
      end
      exp_index = chk_res.next_index;
      pops_seen = int'(chk_res.pop[0]) + int'(chk_res.pop[1]);
    end
  end

  // plays a command queue of n instructions with the reader held off for hold cycles
  task automatic run_cmds(input string name, input int n, input bit two_units,
                          input int hold, input bit sweep);
    int head;
    int cyc;
    head = 0;
    cyc = 0;
    cur_test = name;
    for (int i = 0; i < 64; i++) begin
      cmd_len[i] = sweep ? i % 9 : ($urandom_range(9, 0) == 0) ? 0 : $urandom_range(8, 1);
    end
    while (!aborted && head < n) begin
      de_unit0 = make_unit(1'b1, head, cmd_len[head], int'(exp_index));
      de_unit1 = make_unit(two_units && (head + 1 < n), head + 1, cmd_len[head+1], 0);
      uq_pop = (cyc < hold) ? 1'b0 : ($urandom_range(1, 0) == 1);
      @(negedge clk);
      head += pops_seen;
      cyc++;
      if (hold > 0 && cyc == hold && exp_q.size() <= `UQ_DEPTH - `NUM_DE_UOP) begin
        errors++;
        $display("%s: the queue did not fill while the reader was held off", name);
      end
      if (cyc > 20 * n + hold + 40) begin
        report_timeout("instructions were not popped");
      end
    end
    de_unit0 = '0;
    de_unit1 = '0;
    uq_pop = 1'b0;
  endtask

  task automatic drain_queue();
    int cyc;
    cyc = 0;
    while (!aborted && exp_q.size() != 0) begin
      uq_pop = 1'b1;
      @(negedge clk);
      cyc++;
      if (cyc > 2 * `UQ_DEPTH) begin
        report_timeout("the uop queue did not drain");
      end
    end
    uq_pop = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hda474471));
    errors = 0;
    aborted = 1'b0;
    pops_seen = 0;
    exp_index = '0;
    cur_test = "reset";
    rst_n = 1'b0;
    de_unit0 = '0;
    de_unit1 = '0;
    uq_pop = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_pop("reset", 2'b00, pop);
    check_index("reset", '0, uop_index_remain);
    check_valid("reset", 1'b0, uq_valid);
    @(negedge clk);
    run_cmds("single_unit", 24, 1'b0, 0, 1'b0);
    drain_queue();
    // lengths 0 to 8 in turn give every q from 0 to 4
    run_cmds("two_unit_merge", 27, 1'b1, 0, 1'b1);
    drain_queue();
    run_cmds("back_pressure", 20, 1'b1, 12, 1'b0);
    drain_queue();
    run_cmds("random_drain", 40, 1'b1, 0, 1'b0);
    drain_queue();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hw/decode_pkg.sv
hw/uop_merge.sv
hw/decode_ctrl.sv
hw/uop_queue.sv
hw/decode_uop_top.sv
tb/tb_decode_uop_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_decode_uop_top \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 && cat sim.log || { cat sim.log; echo "run error"; exit 1; }
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no result in log"; exit 1; }
exit 0
